// File: Makefile
# Verilator build and run for the game core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := game_top_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits non-zero on $fatal, so make fails with it
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
hw/game_cfg_pkg.sv
hw/sdram_pkg.sv
hw/video_timer.sv
hw/rom_download.sv
hw/rom_slot_arbiter.sv
hw/game_top.sv
tb/sdram_model.sv
tb/game_top_tb.sv

// File: hw/game_cfg_pkg.sv
/* Game configuration
   SDRAM memory map, ROM slot ids and default video timing */
package game_cfg_pkg;

    localparam int SDRAM_AW  = 22;
    localparam int NUM_SLOTS = 3;
    localparam int NUM_PROMS = 4;

    // Array index of each slot, lower index wins arbitration
    typedef enum logic [1:0] {
        SLOT_CHAR = 2'd0,
        SLOT_MAP  = 2'd1,
        SLOT_MAIN = 2'd2
    } slot_id_e;

    // Region bases in SDRAM words
    localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h00_C000;
    localparam logic [SDRAM_AW-1:0] MAP_OFFSET  = 22'h00_E000;
    // Loader byte address where the colour PROMs start
    localparam logic [SDRAM_AW-1:0] PROM_START  = 22'h02_0000;

    // 384x262 raster, 256x224 visible
    localparam logic [8:0] H_TOTAL  = 9'd384;
    localparam logic [8:0] H_BLANK  = 9'd128;
    localparam logic [8:0] V_TOTAL  = 9'd262;
    localparam logic [8:0] V_BLANK  = 9'd38;
    localparam logic [8:0] HS_START = 9'd280;
    localparam logic [8:0] VS_START = 9'd232;

endpackage

// File: hw/game_top.sv
/* Game core top level
   Video timer, ROM download router and ROM slot arbiter, char slot held off in VBLANK */
`timescale 1ns/1ps

module game_top #(
    parameter logic [8:0] H_TOTAL  = game_cfg_pkg::H_TOTAL,
    parameter logic [8:0] H_BLANK  = game_cfg_pkg::H_BLANK,
    parameter logic [8:0] V_TOTAL  = game_cfg_pkg::V_TOTAL,
    parameter logic [8:0] V_BLANK  = game_cfg_pkg::V_BLANK,
    parameter logic [8:0] HS_START = game_cfg_pkg::HS_START,
    parameter logic [8:0] VS_START = game_cfg_pkg::VS_START,
    parameter logic [21:0] PROM_START  = game_cfg_pkg::PROM_START,
    parameter logic [21:0] CHAR_OFFSET = game_cfg_pkg::CHAR_OFFSET,
    parameter logic [21:0] MAP_OFFSET  = game_cfg_pkg::MAP_OFFSET,
    parameter logic [21:0] MAIN_OFFSET = game_cfg_pkg::MAIN_OFFSET
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                downloading,
    input  logic [21:0]                                         ioctl_addr,
    input  logic [7:0]                                          ioctl_dout,
    input  logic                                                ioctl_wr,
    input  sdram_pkg::slot_req_t [game_cfg_pkg::NUM_SLOTS-1:0]  slot_req,
    output sdram_pkg::slot_rsp_t [game_cfg_pkg::NUM_SLOTS-1:0]  slot_rsp,
    output sdram_pkg::sdram_rd_t                                sdram,
    input  logic                                                sdram_ack,
    input  logic                                                data_rdy,
    input  logic [15:0]                                         data_read,
    output sdram_pkg::prog_wr_t                                 prog,
    output logic [game_cfg_pkg::NUM_PROMS-1:0]                  prom_we,
    output logic [8:0]                                          h,
    output logic [8:0]                                          v,
    output logic                                                lhbl,
    output logic                                                lvbl,
    output logic                                                hs,
    output logic                                                vs,
    output logic                                                pxl_cen
);

    sdram_pkg::slot_req_t [game_cfg_pkg::NUM_SLOTS-1:0] slot_req_gated;

    // Char graphics are only fetched during the active frame
    always_comb begin
        slot_req_gated = slot_req;
        slot_req_gated[game_cfg_pkg::SLOT_CHAR].cs = slot_req[game_cfg_pkg::SLOT_CHAR].cs & lvbl;
    end

    video_timer #(
        .H_TOTAL  (H_TOTAL),
        .H_BLANK  (H_BLANK),
        .V_TOTAL  (V_TOTAL),
        .V_BLANK  (V_BLANK),
        .HS_START (HS_START),
        .VS_START (VS_START)
    ) u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .cen12 (),
        .cen6  (pxl_cen),
        .cen3  (),
        .h     (h),
        .v     (v),
        .hinit (),
        .lhbl  (lhbl),
        .lvbl  (lvbl),
        .hs    (hs),
        .vs    (vs)
    );

    rom_download #(
        .PROM_START (PROM_START)
    ) u_download (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog        (prog),
        .prom_we     (prom_we)
    );

    rom_slot_arbiter #(
        .CHAR_OFFSET (CHAR_OFFSET),
        .MAP_OFFSET  (MAP_OFFSET),
        .MAIN_OFFSET (MAIN_OFFSET)
    ) u_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .slot_req    (slot_req_gated),
        .slot_rsp    (slot_rsp),
        .sdram       (sdram),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

endmodule

// File: hw/rom_download.sv
/* ROM download router
   Game ROM bytes become SDRAM prog writes, colour PROM bytes become PROM strobes */
`timescale 1ns/1ps

module rom_download #(
    parameter logic [game_cfg_pkg::SDRAM_AW-1:0] PROM_START = 22'h02_0000
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 downloading,
    input  logic [21:0]                          ioctl_addr,
    input  logic [7:0]                           ioctl_dout,
    input  logic                                 ioctl_wr,
    input  logic                                 sdram_ack,
    output sdram_pkg::prog_wr_t                  prog,
    output logic [game_cfg_pkg::NUM_PROMS-1:0]   prom_we
);

    localparam int SEL_W = $clog2(game_cfg_pkg::NUM_PROMS);

    logic [21:0]      prom_off;
    logic             in_prom;
    logic [SEL_W-1:0] prom_sel;
    logic             we_q;
    logic [21:0]      addr_q;
    logic [7:0]       data_q;
    logic [1:0]       mask_q;

    assign prom_off = ioctl_addr - PROM_START;
    assign in_prom  = ioctl_addr >= PROM_START && prom_off < game_cfg_pkg::NUM_PROMS * 256;
    // Each PROM is 256 bytes
    assign prom_sel = prom_off[8 +: SEL_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q    <= 1'b0;
            prom_we <= '0;
        end else begin
            prom_we <= '0;
            if (we_q && sdram_ack) we_q <= 1'b0;
            if (downloading && ioctl_wr) begin
                if (ioctl_addr < PROM_START) we_q <= 1'b1;
                else if (in_prom)           prom_we[prom_sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (downloading && ioctl_wr) begin
            data_q <= ioctl_dout;
            if (ioctl_addr < PROM_START) begin
                addr_q <= {1'b0, ioctl_addr[21:1]};
                // Even byte goes to the low lane
                mask_q <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end else begin
                addr_q <= 22'(prom_off[7:0]);
                mask_q <= 2'b11;
            end
        end
    end

    assign prog = '{we: we_q, addr: addr_q, data: data_q, mask: mask_q};

    a_prom_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(prom_we));
    a_prog_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog.we && !sdram_ack |=> prog.we);

endmodule

// File: hw/rom_slot_arbiter.sv
/* ROM slot arbiter
   Fixed-priority sharing of one SDRAM read port among cached 16-bit ROM slots */
`timescale 1ns/1ps

module rom_slot_arbiter #(
    parameter logic [game_cfg_pkg::SDRAM_AW-1:0] CHAR_OFFSET = 22'h00_C000,
    parameter logic [game_cfg_pkg::SDRAM_AW-1:0] MAP_OFFSET  = 22'h00_E000,
    parameter logic [game_cfg_pkg::SDRAM_AW-1:0] MAIN_OFFSET = 22'h00_0000
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                downloading,
    input  sdram_pkg::slot_req_t [game_cfg_pkg::NUM_SLOTS-1:0]  slot_req,
    output sdram_pkg::slot_rsp_t [game_cfg_pkg::NUM_SLOTS-1:0]  slot_rsp,
    output sdram_pkg::sdram_rd_t                                sdram,
    input  logic                                                sdram_ack,
    input  logic                                                data_rdy,
    input  logic [15:0]                                         data_read
);

    localparam int NS = game_cfg_pkg::NUM_SLOTS;
    localparam int AW = game_cfg_pkg::SDRAM_AW;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } state_e;

    state_e                  state;
    game_cfg_pkg::slot_id_e  pick;
    game_cfg_pkg::slot_id_e  sel;
    logic [NS-1:0]           hit;
    logic [NS-1:0]           miss;
    logic [AW-1:0]           cache_addr [NS];
    logic [15:0]             cache_data [NS];
    logic [NS-1:0]           cache_valid;
    logic [AW-1:0]           fetch_addr;
    logic                    req_q;
    logic [AW-1:0]           sdram_addr_q;

    function automatic logic [AW-1:0] slot_offset(input game_cfg_pkg::slot_id_e id);
        case (id)
            game_cfg_pkg::SLOT_CHAR: return CHAR_OFFSET;
            game_cfg_pkg::SLOT_MAP:  return MAP_OFFSET;
            default:                 return MAIN_OFFSET;
        endcase
    endfunction

    // Hits answer straight from the cache registers
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            hit[i]           = slot_req[i].cs && cache_valid[i] &&
                               cache_addr[i] == slot_req[i].addr;
            miss[i]          = slot_req[i].cs && !hit[i];
            slot_rsp[i].ok   = hit[i];
            slot_rsp[i].data = cache_data[i];
        end
    end

    // Scan downwards so the lowest missing index wins
    always_comb begin
        pick = game_cfg_pkg::SLOT_CHAR;
        for (int i = NS - 1; i >= 0; i--) begin
            if (miss[i]) pick = game_cfg_pkg::slot_id_e'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            req_q       <= 1'b0;
            cache_valid <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!downloading && |miss) begin
                        req_q <= 1'b1;
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        req_q <= 1'b0;
                        state <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rdy) begin
                        cache_valid[sel] <= 1'b1;
                        state            <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            // Fresh ROM contents make every cached word stale
            if (downloading) cache_valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && !downloading && |miss) begin
            sel          <= pick;
            fetch_addr   <= slot_req[pick].addr;
            sdram_addr_q <= slot_offset(pick) + slot_req[pick].addr;
        end
        if (state == WAIT_DATA && data_rdy) begin
            cache_addr[sel] <= fetch_addr;
            cache_data[sel] <= data_read;
        end
    end

    assign sdram = '{req: req_q, addr: sdram_addr_q};

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram.req && !sdram_ack |=> sdram.req && $stable(sdram.addr));
    // Read data only comes back for the single outstanding request
    a_one_inflight: assert property (@(posedge clk) disable iff (!rst_n)
        data_rdy && !downloading |-> state == WAIT_DATA);

endmodule

// File: hw/sdram_pkg.sv
/* SDRAM bus structures
   Slot client requests and responses, SDRAM reads and download writes */
package sdram_pkg;

    // Word address relative to the slot's region
    typedef struct packed {
        logic                                cs;
        logic [game_cfg_pkg::SDRAM_AW-1:0]   addr;
    } slot_req_t;

    typedef struct packed {
        logic           ok;
        logic [15:0]    data;
    } slot_rsp_t;

    typedef struct packed {
        logic                                req;
        logic [game_cfg_pkg::SDRAM_AW-1:0]   addr;
    } sdram_rd_t;

    // mask bit set means that byte lane is left untouched
    typedef struct packed {
        logic                                we;
        logic [game_cfg_pkg::SDRAM_AW-1:0]   addr;
        logic [7:0]                          data;
        logic [1:0]                          mask;
    } prog_wr_t;

endpackage

// File: hw/video_timer.sv
/* Video timer
   Pixel clock enables from the 48 MHz clock, H/V counters, blanking and syncs */
`timescale 1ns/1ps

module video_timer #(
    parameter logic [8:0] H_TOTAL  = 9'd384,
    parameter logic [8:0] H_BLANK  = 9'd128,
    parameter logic [8:0] V_TOTAL  = 9'd262,
    parameter logic [8:0] V_BLANK  = 9'd38,
    parameter logic [8:0] HS_START = 9'd280,
    parameter logic [8:0] VS_START = 9'd232
) (
    input  logic       clk,
    input  logic       rst_n,
    output logic       cen12,
    output logic       cen6,
    output logic       cen3,
    output logic [8:0] h,
    output logic [8:0] v,
    output logic       hinit,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs
);

    logic [3:0] div;
    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) div <= 4'd0;
        else        div <= div + 4'd1;
    end

    // 12, 6 and 3 MHz enables, nested so cen3 implies cen6 implies cen12
    assign cen12 = &div[1:0];
    assign cen6  = &div[2:0];
    assign cen3  = &div;

    always_comb begin
        h_nxt = h + 9'd1;
        v_nxt = v;
        if (h == H_TOTAL - 9'd1) begin
            h_nxt = 9'd0;
            v_nxt = (v == V_TOTAL - 9'd1) ? 9'd0 : v + 9'd1;
        end
    end

    // Flags are decoded from the next count so they line up with h and v
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h     <= 9'd0;
            v     <= 9'd0;
            hinit <= 1'b1;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (cen6) begin
            h     <= h_nxt;
            v     <= v_nxt;
            hinit <= h_nxt == 9'd0;
            lhbl  <= h_nxt < H_TOTAL - H_BLANK;
            lvbl  <= v_nxt < V_TOTAL - V_BLANK;
            hs    <= h_nxt >= HS_START && h_nxt < HS_START + 9'd32;
            vs    <= v_nxt >= VS_START && v_nxt < VS_START + 9'd4;
        end
    end

    a_h_range: assert property (@(posedge clk) disable iff (!rst_n) h < H_TOTAL);
    a_cen_nest: assert property (@(posedge clk) disable iff (!rst_n) cen6 |-> cen12);

endmodule

// File: tb/game_top_tb.sv
/* Testbench for the game core top level
   Table-driven checks of video timing, ROM download and ROM slot fetches */
`timescale 1ns/1ps

module game_top_tb;

    localparam int NS         = game_cfg_pkg::NUM_SLOTS;
    localparam int NP         = game_cfg_pkg::NUM_PROMS;
    localparam int LINE_CLKS  = int'(game_cfg_pkg::H_TOTAL) * 8;
    localparam int FRAME_CLKS = LINE_CLKS * int'(game_cfg_pkg::V_TOTAL);

    typedef enum {K_RESET, K_VIDEO, K_PROG, K_PROM, K_FETCH, K_PAIR, K_HIT, K_BLANK} kind_e;

    typedef struct {
        string                   name;
        kind_e                   kind;
        game_cfg_pkg::slot_id_e  slot;
        logic [21:0]             addr;
        logic [21:0]             ld_addr;
        logic [7:0]              ld_byte;
        logic [31:0]             expect_val;
    } step_t;

    logic                           clk;
    logic                           rst_n;
    logic                           downloading;
    logic [21:0]                    ioctl_addr;
    logic [7:0]                     ioctl_dout;
    logic                           ioctl_wr;
    logic                           sdram_ack;
    logic                           data_rdy;
    logic [15:0]                    data_read;
    logic [8:0]                     h;
    logic [8:0]                     v;
    logic                           lhbl;
    logic                           lvbl;
    logic                           hs;
    logic                           vs;
    logic                           pxl_cen;
    logic [NP-1:0]                  prom_we;
    sdram_pkg::slot_req_t [NS-1:0]  slot_req;
    sdram_pkg::slot_rsp_t [NS-1:0]  slot_rsp;
    sdram_pkg::sdram_rd_t           sdram;
    sdram_pkg::prog_wr_t            prog;

    step_t                          steps[$];
    sdram_pkg::sdram_rd_t           rd_log[$];
    int                             cycles = 0;
    int                             limit = 0;

    game_top dut0 (.*);

    sdram_model u_sdram (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (sdram),
        .prog      (prog),
        .ack       (sdram_ack),
        .data_rdy  (data_rdy),
        .data_read (data_read)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Accepted SDRAM reads in the order the model took them
    always @(posedge clk) begin
        if (rst_n && sdram.req && sdram_ack) rd_log.push_back(sdram);
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the run went past %0d clock cycles", limit);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_error(input string name, input string exp, input string act);
        $display("ERROR %s: expected %s, actual %s", name, exp, act);
        fail_run();
    endtask

    task automatic check_rsp(input string name, input sdram_pkg::slot_rsp_t exp, act);
        if (act !== exp) value_error(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_prog(input string name, input sdram_pkg::prog_wr_t exp, act);
        if (act !== exp) value_error(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_prom(input string name, input logic [NP-1:0] exp, act);
        if (act !== exp) value_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        if (act !== exp) value_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_rd(input string name, input sdram_pkg::sdram_rd_t exp, act);
        if (act !== exp) value_error(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_count(input string name, input int exp, act);
        if (act != exp) value_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    function automatic logic [21:0] region_base(input game_cfg_pkg::slot_id_e slot);
        case (slot)
            game_cfg_pkg::SLOT_CHAR: return game_cfg_pkg::CHAR_OFFSET;
            game_cfg_pkg::SLOT_MAP:  return game_cfg_pkg::MAP_OFFSET;
            default:                 return game_cfg_pkg::MAIN_OFFSET;
        endcase
    endfunction

    // Word the SDRAM holds for a slot address
    function automatic logic [15:0] slot_word(input game_cfg_pkg::slot_id_e slot,
                                              input logic [21:0] addr);
        logic [21:0] word_addr;
        word_addr = region_base(slot) + addr;
        return word_addr[15:0] ^ 16'hA5A5;
    endfunction

    task automatic add_step(input string name, input kind_e kind,
                            input game_cfg_pkg::slot_id_e slot, input logic [21:0] addr,
                            input logic [21:0] ld_addr, input logic [7:0] ld_byte,
                            input logic [31:0] expect_val);
        steps.push_back('{name, kind, slot, addr, ld_addr, ld_byte, expect_val});
    endtask

    task automatic build_table();
        add_step("reset_idle", K_RESET, game_cfg_pkg::SLOT_CHAR, '0, '0, '0, '0);
        add_step("video_timing", K_VIDEO, game_cfg_pkg::SLOT_CHAR, '0, '0, '0, '0);
        // Expected word address is the byte address halved, lane mask in bits 23:22
        // Even byte lands in the low lane, so the high lane is masked
        add_step("prog_even", K_PROG, game_cfg_pkg::SLOT_CHAR, '0,
                 22'h00_1234, 8'h5C, 32'h0080_091A);
        add_step("prog_odd", K_PROG, game_cfg_pkg::SLOT_CHAR, '0,
                 22'h01_ABCD, 8'hE7, 32'h0040_D5E6);
        for (int k = 0; k < NP; k++) begin
            add_step($sformatf("prom_%0d", k), K_PROM, game_cfg_pkg::SLOT_CHAR, '0,
                     game_cfg_pkg::PROM_START + 22'(k * 256 + k * 16 + 5),
                     8'(8'h30 + k), 32'(1) << k);
        end
        add_step("fetch_char", K_FETCH, game_cfg_pkg::SLOT_CHAR, 22'h00_0123, '0, '0,
                 32'(slot_word(game_cfg_pkg::SLOT_CHAR, 22'h00_0123)));
        add_step("fetch_map", K_FETCH, game_cfg_pkg::SLOT_MAP, 22'h00_0456, '0, '0,
                 32'(slot_word(game_cfg_pkg::SLOT_MAP, 22'h00_0456)));
        add_step("fetch_main", K_FETCH, game_cfg_pkg::SLOT_MAIN, 22'h00_3F00, '0, '0,
                 32'(slot_word(game_cfg_pkg::SLOT_MAIN, 22'h00_3F00)));
        add_step("pair_map_main", K_PAIR, game_cfg_pkg::SLOT_MAP, 22'h00_0777, '0, '0,
                 {slot_word(game_cfg_pkg::SLOT_MAIN, 22'h00_0777),
                  slot_word(game_cfg_pkg::SLOT_MAP, 22'h00_0777)});
        add_step("hit_map", K_HIT, game_cfg_pkg::SLOT_MAP, 22'h00_0777, '0, '0,
                 32'(slot_word(game_cfg_pkg::SLOT_MAP, 22'h00_0777)));
        add_step("blank_char", K_BLANK, game_cfg_pkg::SLOT_CHAR, 22'h00_0200, '0, '0,
                 32'(slot_word(game_cfg_pkg::SLOT_CHAR, 22'h00_0200)));
    endtask

    task automatic video_timing(input step_t s);
        int n;
        int cens;
        int vs_clks;
        while (hs) @(negedge clk);
        while (!hs) @(negedge clk);
        n    = 0;
        cens = 0;
        while (hs) begin
            @(negedge clk);
            n++;
            if (pxl_cen) cens++;
        end
        while (!hs) begin
            @(negedge clk);
            n++;
            if (pxl_cen) cens++;
        end
        check_count({s.name, " hs period"}, LINE_CLKS, n);
        check_count({s.name, " pixels per line"}, int'(game_cfg_pkg::H_TOTAL), cens);
        // Horizontal blanking lasts H_BLANK pixels of 8 clocks
        while (!lhbl) @(negedge clk);
        while (lhbl) @(negedge clk);
        n = 0;
        while (!lhbl) begin
            @(negedge clk);
            n++;
        end
        check_count({s.name, " hblank clocks"}, int'(game_cfg_pkg::H_BLANK) * 8, n);
        while (lvbl) @(negedge clk);
        n       = 0;
        vs_clks = 0;
        while (!lvbl) begin
            @(negedge clk);
            n++;
            if (vs) vs_clks++;
        end
        check_count({s.name, " vblank clocks"}, int'(game_cfg_pkg::V_BLANK) * LINE_CLKS, n);
        // Vertical sync is 4 lines inside the blanking
        check_count({s.name, " vsync clocks"}, 4 * LINE_CLKS, vs_clks);
    endtask

    task automatic download(input step_t s);
        sdram_pkg::prog_wr_t exp;
        logic                acked;
        downloading = 1'b1;
        ioctl_addr  = s.ld_addr;
        ioctl_dout  = s.ld_byte;
        ioctl_wr    = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (s.kind == K_PROM) begin
            check_prom(s.name, s.expect_val[NP-1:0], prom_we);
            check_bit({s.name, " prog idle"}, 1'b0, prog.we);
            @(negedge clk);
            check_prom({s.name, " strobe end"}, '0, prom_we);
        end else begin
            exp   = '{we: 1'b1, addr: s.expect_val[21:0], data: s.ld_byte,
                      mask: s.expect_val[23:22]};
            acked = 1'b0;
            check_prom({s.name, " no prom"}, '0, prom_we);
            while (prog.we) begin
                check_prog(s.name, exp, prog);
                acked = sdram_ack;
                @(negedge clk);
            end
            check_bit({s.name, " held until ack"}, 1'b1, acked);
        end
        downloading = 1'b0;
    endtask

    task automatic fetch(input step_t s);
        int                    n;
        sdram_pkg::sdram_rd_t  exp_rd;
        sdram_pkg::slot_rsp_t  exp_rsp;
        n       = rd_log.size();
        exp_rd  = '{req: 1'b1, addr: region_base(s.slot) + s.addr};
        exp_rsp = '{ok: 1'b1, data: s.expect_val[15:0]};
        if (s.kind == K_BLANK) begin
            while (lvbl) @(negedge clk);
        end
        slot_req[s.slot] = '{cs: 1'b1, addr: s.addr};
        @(negedge clk);
        while (!lvbl) begin
            check_bit({s.name, " req in vblank"}, 1'b0, sdram.req);
            @(negedge clk);
        end
        while (!slot_rsp[s.slot].ok) @(negedge clk);
        check_rsp(s.name, exp_rsp, slot_rsp[s.slot]);
        check_count({s.name, " reads"}, n + 1, rd_log.size());
        check_rd(s.name, exp_rd, rd_log[n]);
        slot_req = '0;
    endtask

    task automatic fetch_pair(input step_t s);
        int                    n;
        sdram_pkg::sdram_rd_t  exp_rd;
        sdram_pkg::slot_rsp_t  exp_rsp;
        n = rd_log.size();
        slot_req[game_cfg_pkg::SLOT_MAP]  = '{cs: 1'b1, addr: s.addr};
        slot_req[game_cfg_pkg::SLOT_MAIN] = '{cs: 1'b1, addr: s.addr};
        @(negedge clk);
        while (!(slot_rsp[game_cfg_pkg::SLOT_MAP].ok && slot_rsp[game_cfg_pkg::SLOT_MAIN].ok))
            @(negedge clk);
        check_count({s.name, " reads"}, n + 2, rd_log.size());
        // MAP outranks MAIN
        exp_rd = '{req: 1'b1, addr: game_cfg_pkg::MAP_OFFSET + s.addr};
        check_rd({s.name, " first"}, exp_rd, rd_log[n]);
        exp_rd = '{req: 1'b1, addr: game_cfg_pkg::MAIN_OFFSET + s.addr};
        check_rd({s.name, " second"}, exp_rd, rd_log[n + 1]);
        exp_rsp = '{ok: 1'b1, data: s.expect_val[15:0]};
        check_rsp({s.name, " map"}, exp_rsp, slot_rsp[game_cfg_pkg::SLOT_MAP]);
        exp_rsp = '{ok: 1'b1, data: s.expect_val[31:16]};
        check_rsp({s.name, " main"}, exp_rsp, slot_rsp[game_cfg_pkg::SLOT_MAIN]);
        slot_req = '0;
    endtask

    task automatic fetch_hit(input step_t s);
        int                    n;
        sdram_pkg::slot_rsp_t  exp_rsp;
        n       = rd_log.size();
        exp_rsp = '{ok: 1'b1, data: s.expect_val[15:0]};
        slot_req[s.slot] = '{cs: 1'b1, addr: s.addr};
        @(negedge clk);
        check_rsp(s.name, exp_rsp, slot_rsp[s.slot]);
        check_bit({s.name, " no req"}, 1'b0, sdram.req);
        check_count({s.name, " reads"}, n, rd_log.size());
        slot_req = '0;
    endtask

    initial begin
        void'($urandom(56));
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        slot_req    = '0;
        build_table();
        // Two frames cover the video and blank steps
        limit = steps.size() * 64 + 2 * FRAME_CLKS;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            case (steps[i].kind)
                K_RESET: begin
                    check_bit({steps[i].name, " sdram req"}, 1'b0, sdram.req);
                    check_bit({steps[i].name, " prog we"}, 1'b0, prog.we);
                    check_prom({steps[i].name, " prom we"}, '0, prom_we);
                    check_count({steps[i].name, " h"}, 0, int'(h));
                    check_count({steps[i].name, " v"}, 0, int'(v));
                end
                K_VIDEO:        video_timing(steps[i]);
                K_PROG, K_PROM: download(steps[i]);
                K_PAIR:         fetch_pair(steps[i]);
                K_HIT:          fetch_hit(steps[i]);
                default:        fetch(steps[i]);
            endcase
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tb/sdram_model.sv
/* Behavioural SDRAM
   Answers reads and download writes after a random 1 to 4 cycle latency */
`timescale 1ns/1ps

module sdram_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sdram_pkg::sdram_rd_t  rd,
    input  sdram_pkg::prog_wr_t   prog,
    output logic                  ack = 1'b0,
    output logic                  data_rdy = 1'b0,
    output logic [15:0]           data_read = 16'h0000
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_ACK,
        M_DATA,
        M_DONE
    } mstate_e;

    mstate_e                             state;
    logic [2:0]                          wait_cnt;
    logic                                is_read;
    logic [game_cfg_pkg::SDRAM_AW-1:0]   addr_q;

    function automatic logic [2:0] latency();
        return 3'($urandom % 4) + 3'd1;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            state    <= M_IDLE;
            ack      <= 1'b0;
            data_rdy <= 1'b0;
        end else begin
            ack      <= 1'b0;
            data_rdy <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (rd.req || prog.we) begin
                        is_read  <= rd.req;
                        addr_q   <= rd.addr;
                        wait_cnt <= latency();
                        state    <= M_ACK;
                    end
                end
                M_ACK: begin
                    if (wait_cnt == 3'd1) begin
                        ack      <= 1'b1;
                        wait_cnt <= latency();
                        state    <= is_read ? M_DATA : M_DONE;
                    end else begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end
                end
                M_DATA: begin
                    if (wait_cnt == 3'd1) begin
                        data_rdy  <= 1'b1;
                        // ROM contents follow the word address
                        data_read <= addr_q[15:0] ^ 16'hA5A5;
                        state     <= M_DONE;
                    end else begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end
                end
                // One idle cycle lets the request drop after ack
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule
